/* Makefile */
# Verilator build and run for the data cache testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Test passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/dcache_defines.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line appears in the simulator output
run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/dcache.sv */
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache (
   input  logic              CLK,
   input  logic              nRST,
   // processor side
   input  logic              dmem_ren,
   input  logic              dmem_wen,
   input  dcache_pkg::addr_t dmem_addr,
   input  dcache_pkg::word_t dmem_store,
   input  logic              halt,
   output logic              dhit,
   output dcache_pkg::word_t dmem_load,
   output logic              flushed,
   // memory side
   output logic              d_ren,
   output logic              d_wen,
   output dcache_pkg::addr_t d_addr,
   output dcache_pkg::word_t d_store,
   input  dcache_pkg::word_t d_load,
   input  logic              d_wait
);

   import dcache_pkg::*;

   // index and strobes from the controller
   set_idx_t idx;
   logic     wr_en, wr_wsel, fill_done, mark_dirty, clean_en, touch_en;
   way_t     wr_way, touch_way;
   word_t    wr_data;
   tag_t     fill_tag;

   // selected set
   tag_t                set_tag [`DC_WAYS];
   logic [`DC_WAYS-1:0] set_valid, set_dirty;
   word_t               set_data [`DC_WAYS][`DC_WORDS];
   way_t                set_lru;

   // lookup results
   logic  hit, victim_dirty;
   way_t  hit_way, victim_way;
   tag_t  victim_tag;
   word_t victim_word0, victim_word1;

   dcache_store u_store (
      .CLK, .nRST, .idx, .wr_en, .wr_way, .wr_wsel, .wr_data,
      .fill_done, .fill_tag, .mark_dirty, .clean_en, .touch_en, .touch_way,
      .set_tag, .set_valid, .set_dirty, .set_data, .set_lru
   );

   dcache_lookup u_lookup (
      .req_tag   (dmem_addr[`DC_ADDR_W-1:`DC_TAG_LSB]),
      .wsel      (dmem_addr[`DC_WSEL_BIT]),
      .set_tag, .set_valid, .set_dirty, .set_data, .set_lru,
      .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
      .victim_word0, .victim_word1,
      .load_data (dmem_load)
   );

   dcache_ctrl u_ctrl (
      .CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
      .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
      .victim_word0, .victim_word1, .set_tag, .set_valid, .set_dirty, .set_data,
      .d_load, .d_wait, .idx, .wr_en, .wr_way, .wr_wsel, .wr_data,
      .fill_done, .fill_tag, .mark_dirty, .clean_en, .touch_en, .touch_way,
      .dhit, .flushed, .d_ren, .d_wen, .d_addr, .d_store
   );

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_ctrl (
   input  logic                 CLK,
   input  logic                 nRST,
   input  logic                 dmem_ren,
   input  logic                 dmem_wen,
   input  dcache_pkg::addr_t    dmem_addr,
   input  dcache_pkg::word_t    dmem_store,
   input  logic                 halt,
   input  logic                 hit,
   input  dcache_pkg::way_t     hit_way,
   input  dcache_pkg::way_t     victim_way,
   input  logic                 victim_dirty,
   input  dcache_pkg::tag_t     victim_tag,
   input  dcache_pkg::word_t    victim_word0,
   input  dcache_pkg::word_t    victim_word1,
   input  dcache_pkg::tag_t     set_tag [`DC_WAYS],
   input  logic [`DC_WAYS-1:0]  set_valid,
   input  logic [`DC_WAYS-1:0]  set_dirty,
   input  dcache_pkg::word_t    set_data [`DC_WAYS][`DC_WORDS],
   input  dcache_pkg::word_t    d_load,
   input  logic                 d_wait,
   output dcache_pkg::set_idx_t idx,
   output logic                 wr_en,
   output dcache_pkg::way_t     wr_way,
   output logic                 wr_wsel,
   output dcache_pkg::word_t    wr_data,
   output logic                 fill_done,
   output dcache_pkg::tag_t     fill_tag,
   output logic                 mark_dirty,
   output logic                 clean_en,
   output logic                 touch_en,
   output dcache_pkg::way_t     touch_way,
   output logic                 dhit,
   output logic                 flushed,
   output logic                 d_ren,
   output logic                 d_wen,
   output dcache_pkg::addr_t    d_addr,
   output dcache_pkg::word_t    d_store
);

   import dcache_pkg::*;

   cache_state_t state_q;
   cache_state_t state_d;
   slot_t        slot_q;
   slot_t        slot_d;

   // request fields
   tag_t     req_tag;
   set_idx_t req_idx;
   logic     req_wsel;
   logic     req;

   // flush slot fields
   set_idx_t slot_set;
   way_t     slot_way;
   logic     slot_done;

   // word address of one block word, byte offset zero
   function automatic addr_t block_addr(tag_t tag, set_idx_t set, logic wsel);
      return {tag, set, wsel, {`DC_WSEL_BIT{1'b0}}};
   endfunction

   assign req_tag  = dmem_addr[`DC_ADDR_W-1:`DC_TAG_LSB];
   assign req_idx  = dmem_addr[`DC_TAG_LSB-1:`DC_IDX_LSB];
   assign req_wsel = dmem_addr[`DC_WSEL_BIT];
   assign req      = dmem_ren || dmem_wen;

   assign slot_set  = slot_q[`DC_IDX_W-1:0];
   assign slot_way  = slot_q[`DC_IDX_W];
   assign slot_done = slot_q[`DC_SLOT_W-1];

   // the fill always brings in the requested block
   assign fill_tag = req_tag;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         state_q <= IDLE;
         slot_q  <= '0;
      end
      else
      begin
         state_q <= state_d;
         slot_q  <= slot_d;
      end
   end

   always_comb
   begin
      state_d    = state_q;
      slot_d     = slot_q;
      idx        = req_idx;
      wr_en      = 1'b0;
      // LRU stays put through the miss, so the lookup victim is stable
      wr_way     = victim_way;
      wr_wsel    = 1'b0;
      wr_data    = d_load;
      fill_done  = 1'b0;
      mark_dirty = 1'b0;
      clean_en   = 1'b0;
      touch_en   = 1'b0;
      touch_way  = hit_way;
      dhit       = 1'b0;
      flushed    = 1'b0;
      d_ren      = 1'b0;
      d_wen      = 1'b0;
      d_addr     = block_addr(req_tag, req_idx, 1'b0);
      d_store    = victim_word0;
      case (state_q)
         IDLE:
         begin
            // halt wins over a pending request
            if (halt)
            begin
               slot_d  = '0;
               state_d = FLUSH_SCAN;
            end
            else if (req && hit)
            begin
               dhit     = 1'b1;
               touch_en = 1'b1;
               if (dmem_wen)
               begin
                  wr_en      = 1'b1;
                  wr_way     = hit_way;
                  wr_wsel    = req_wsel;
                  wr_data    = dmem_store;
                  mark_dirty = 1'b1;
               end
            end
            else if (req)
            begin
               state_d = victim_dirty ? WB0 : FILL0;
            end
         end
         WB0:
         begin
            d_wen  = 1'b1;
            d_addr = block_addr(victim_tag, req_idx, 1'b0);
            if (!d_wait)
            begin
               state_d = WB1;
            end
         end
         WB1:
         begin
            d_wen   = 1'b1;
            d_addr  = block_addr(victim_tag, req_idx, 1'b1);
            d_store = victim_word1;
            // no clean needed, the fill clears dirty
            if (!d_wait)
            begin
               state_d = FILL0;
            end
         end
         FILL0:
         begin
            d_ren = 1'b1;
            if (!d_wait)
            begin
               wr_en   = 1'b1;
               state_d = FILL1;
            end
         end
         FILL1:
         begin
            d_ren   = 1'b1;
            d_addr  = block_addr(req_tag, req_idx, 1'b1);
            wr_wsel = 1'b1;
            // second word, tag and valid all land on this edge
            if (!d_wait)
            begin
               wr_en     = 1'b1;
               fill_done = 1'b1;
               state_d   = IDLE;
            end
         end
         FLUSH_SCAN:
         begin
            idx = slot_set;
            if (slot_done)
            begin
               state_d = HALTED;
            end
            else if (set_valid[slot_way] && set_dirty[slot_way])
            begin
               state_d = FLUSH0;
            end
            else
            begin
               slot_d = slot_q + slot_t'(1);
            end
         end
         FLUSH0:
         begin
            idx     = slot_set;
            d_wen   = 1'b1;
            d_addr  = block_addr(set_tag[slot_way], slot_set, 1'b0);
            d_store = set_data[slot_way][0];
            if (!d_wait)
            begin
               state_d = FLUSH1;
            end
         end
         FLUSH1:
         begin
            idx     = slot_set;
            d_wen   = 1'b1;
            d_addr  = block_addr(set_tag[slot_way], slot_set, 1'b1);
            d_store = set_data[slot_way][1];
            wr_way  = slot_way;
            if (!d_wait)
            begin
               clean_en = 1'b1;
               slot_d   = slot_q + slot_t'(1);
               state_d  = FLUSH_SCAN;
            end
         end
         HALTED:
         begin
            // only reset leaves
            flushed = 1'b1;
         end
         default:
         begin
            state_d = IDLE;
         end
      endcase
   end

endmodule

/* rtl/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// data and address widths
`define DC_WORD_W     32
`define DC_ADDR_W     32

// organization of the array
`define DC_SETS       8
`define DC_WAYS       2
`define DC_WORDS      2

// address layout {tag, index, word select, byte offset}
`define DC_TAG_W      26
`define DC_TAG_LSB    6
`define DC_IDX_W      3
`define DC_IDX_LSB    3
`define DC_WSEL_BIT   2

// flush walk covers sets x ways plus one done value
`define DC_SLOT_W     5

`endif

/* rtl/dcache_lookup.sv */
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_lookup (
   input  dcache_pkg::tag_t    req_tag,
   input  logic                wsel,
   input  dcache_pkg::tag_t    set_tag [`DC_WAYS],
   input  logic [`DC_WAYS-1:0] set_valid,
   input  logic [`DC_WAYS-1:0] set_dirty,
   input  dcache_pkg::word_t   set_data [`DC_WAYS][`DC_WORDS],
   input  dcache_pkg::way_t    set_lru,
   output logic                hit,
   output dcache_pkg::way_t    hit_way,
   output dcache_pkg::way_t    victim_way,
   output logic                victim_dirty,
   output dcache_pkg::tag_t    victim_tag,
   output dcache_pkg::word_t   victim_word0,
   output dcache_pkg::word_t   victim_word1,
   output dcache_pkg::word_t   load_data
);

   import dcache_pkg::*;

   // per way tag match
   logic [`DC_WAYS-1:0] match;

   always_comb
   begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
         // an invalid way never matches, whatever its stale tag
         match[w] = set_valid[w] && (set_tag[w] == req_tag);
      end
   end

   assign hit = |match;

   // two ways, so way 1 matching is the whole encoding
   // both ways never hold the same tag, fills only go to a missing tag
   assign hit_way = way_t'(match[1]);

   // LRU bit names the way to replace
   assign victim_way = set_lru;

   // write-back only needed for a dirty block still valid
   assign victim_dirty = set_valid[set_lru] && set_dirty[set_lru];

   // address and payload of the victim for the write-back
   assign victim_tag   = set_tag[set_lru];
   assign victim_word0 = set_data[set_lru][0];
   assign victim_word1 = set_data[set_lru][1];

   // load word of the hit way
   // meaningless on a miss, dhit is low then
   assign load_data = set_data[hit_way][wsel];

endmodule

/* rtl/dcache_pkg.sv */
`include "dcache_defines.svh"

package dcache_pkg;

   // one data word on either bus
   typedef logic [`DC_WORD_W-1:0] word_t;

   // byte address from the processor
   typedef logic [`DC_ADDR_W-1:0] addr_t;

   // upper address bits kept per way
   typedef logic [`DC_TAG_W-1:0] tag_t;

   // set select
   typedef logic [`DC_IDX_W-1:0] set_idx_t;

   // way number inside a set
   typedef logic way_t;

   // flush walk position
   // low bits pick the set, next bit the way, top bit means done
   typedef logic [`DC_SLOT_W-1:0] slot_t;

   // controller states
   typedef enum logic [3:0] {
      IDLE, WB0, WB1, FILL0, FILL1, FLUSH_SCAN, FLUSH0, FLUSH1, HALTED
   } cache_state_t;

endpackage

/* rtl/dcache_store.sv */
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_store (
   input  logic                 CLK,
   input  logic                 nRST,
   input  dcache_pkg::set_idx_t idx,
   input  logic                 wr_en,
   input  dcache_pkg::way_t     wr_way,
   input  logic                 wr_wsel,
   input  dcache_pkg::word_t    wr_data,
   input  logic                 fill_done,
   input  dcache_pkg::tag_t     fill_tag,
   input  logic                 mark_dirty,
   input  logic                 clean_en,
   input  logic                 touch_en,
   input  dcache_pkg::way_t     touch_way,
   output dcache_pkg::tag_t     set_tag [`DC_WAYS],
   output logic [`DC_WAYS-1:0]  set_valid,
   output logic [`DC_WAYS-1:0]  set_dirty,
   output dcache_pkg::word_t    set_data [`DC_WAYS][`DC_WORDS],
   output dcache_pkg::way_t     set_lru
);

   import dcache_pkg::*;

   // payload arrays, indexed way then set
   tag_t  tag_mem  [`DC_WAYS][`DC_SETS];
   word_t data_mem [`DC_WAYS][`DC_SETS][`DC_WORDS];

   // state bits, one per way slot
   logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
   logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;

   // per set, the way to evict next
   way_t lru_q [`DC_SETS];

   // tag and data writes
   always_ff @(posedge CLK)
   begin
      // one word per cycle, from a fill or a write hit
      if (wr_en)
      begin
         data_mem[wr_way][idx][wr_wsel] <= wr_data;
      end
      // tag lands together with the last fill word
      if (fill_done)
      begin
         tag_mem[wr_way][idx] <= fill_tag;
      end
   end

   // valid, dirty and LRU
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (!nRST)
      begin
         valid_q <= '0;
         dirty_q <= '0;
         for (int s = 0; s < `DC_SETS; s++)
         begin
            lru_q[s] <= 1'b0;
         end
      end
      else
      begin
         // a completed fill is a clean valid block
         if (fill_done)
         begin
            valid_q[wr_way][idx] <= 1'b1;
            dirty_q[wr_way][idx] <= 1'b0;
         end
         // flush wrote the block back
         if (clean_en)
         begin
            dirty_q[wr_way][idx] <= 1'b0;
         end
         // write hit
         if (wr_en && mark_dirty)
         begin
            dirty_q[wr_way][idx] <= 1'b1;
         end
         // the other way becomes the victim
         if (touch_en)
         begin
            lru_q[idx] <= ~touch_way;
         end
      end
   end

   // selected set, read combinationally
   always_comb
   begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
         set_tag[w]   = tag_mem[w][idx];
         set_valid[w] = valid_q[w][idx];
         set_dirty[w] = dirty_q[w][idx];
         for (int k = 0; k < `DC_WORDS; k++)
         begin
            set_data[w][k] = data_mem[w][idx][k];
         end
      end
      set_lru = lru_q[idx];
   end

endmodule

/* verification/dcache_props.sv */
`timescale 1ns/100ps

module dcache_props (
   input logic              CLK,
   input logic              nRST,
   input logic              dmem_ren,
   input logic              dmem_wen,
   input dcache_pkg::addr_t dmem_addr,
   input logic              dhit,
   input logic              flushed,
   input logic              d_ren,
   input logic              d_wen,
   input dcache_pkg::addr_t d_addr,
   input dcache_pkg::word_t d_store,
   input logic              d_wait
);

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   // a word transfer is requested on the memory side
   logic xfer;
   assign xfer = d_ren || d_wen;

   // outputs come out of reset quiet
   assert property (@(posedge CLK) $rose(nRST) |-> !xfer && !dhit && !flushed)
   else
   begin
      fail_count++;
      $error("memory request or status flag high when reset was released");
   end

   // transfers are word aligned
   assert property (@(posedge CLK) disable iff (!nRST) xfer |-> d_addr[1:0] == 2'b00)
   else
   begin
      fail_count++;
      $error("memory transfer address has a nonzero byte offset");
   end

   // a completed word 0 is followed at once by word 1 of the same block
   assert property (@(posedge CLK) disable iff (!nRST)
      xfer && !d_wait && !d_addr[2] |=>
         d_ren == $past(d_ren) && d_wen == $past(d_wen) &&
         d_addr == {$past(d_addr[31:3]), 3'b100})
   else
   begin
      fail_count++;
      $error("word 0 transfer not followed by word 1 of the same block");
   end

   // word 1 only after word 0, or while word 1 itself stalls
   assert property (@(posedge CLK) disable iff (!nRST)
      xfer && d_addr[2] |-> $past(xfer) && $past(d_addr[31:3]) == d_addr[31:3])
   else
   begin
      fail_count++;
      $error("word 1 transfer without a preceding transfer to the same block");
   end

   // write-back never hits the block being requested
   assert property (@(posedge CLK) disable iff (!nRST)
      d_wen && (dmem_ren || dmem_wen) |-> d_addr[31:3] != dmem_addr[31:3])
   else
   begin
      fail_count++;
      $error("write-back targets the block of the pending request");
   end

   // memory side held while the memory stalls
   assert property (@(posedge CLK) disable iff (!nRST)
      xfer && d_wait |=>
         $stable(d_ren) && $stable(d_wen) && $stable(d_addr) && $stable(d_store))
   else
   begin
      fail_count++;
      $error("memory request changed while d_wait was high");
   end

   // no hit while the memory bus is busy
   assert property (@(posedge CLK) disable iff (!nRST) !(dhit && xfer))
   else
   begin
      fail_count++;
      $error("dhit high during a memory transfer");
   end

   // flushed is sticky until reset
   assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed)
   else
   begin
      fail_count++;
      $error("flushed fell without a reset");
   end

endmodule

/* verification/tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache;

   import dcache_pkg::*;

   localparam int          CLK_PERIOD    = 8;
   localparam int          RESET_CYCLES  = 10;
   localparam int          NUM_REQ       = 400;
   localparam int          CYCLES_PER_OP = 40;
   localparam int          FLUSH_SLOTS   = 16;
   localparam logic [15:0] SEED          = 16'd43102;
   // three neighbouring tags give every set conflicts and evictions
   localparam tag_t        TAG_BASE      = 26'h40;
   // worst case for every request and flush slot plus reset and some slack
   localparam int WATCHDOG_CYCLES =
      NUM_REQ * CYCLES_PER_OP + FLUSH_SLOTS * CYCLES_PER_OP + RESET_CYCLES + 20;

   logic  CLK;
   logic  nRST;
   logic  dmem_ren;
   logic  dmem_wen;
   addr_t dmem_addr;
   word_t dmem_store;
   logic  halt;
   logic  dhit;
   word_t dmem_load;
   logic  flushed;
   logic  d_ren;
   logic  d_wen;
   addr_t d_addr;
   word_t d_store;
   word_t d_load;
   logic  d_wait;

   // separate LFSR states for the processor stream and the memory wait states
   logic [15:0] stim_lfsr = SEED;
   logic [15:0] wait_lfsr = SEED;

   // reference value for the read in flight
   word_t expected_load = '0;
   logic  started = 1'b0;
   int    check_errors = 0;
   int    mem_errors = 0;

   // behavioral memory and the last value the processor wrote per address
   word_t mem    [addr_t];
   word_t shadow [addr_t];

   dcache u_dut (
      .CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
      .dhit, .dmem_load, .flushed,
      .d_ren, .d_wen, .d_addr, .d_store, .d_load, .d_wait
   );

   bind dcache dcache_props u_props (
      .CLK, .nRST, .dmem_ren, .dmem_wen, .dmem_addr, .dhit, .flushed,
      .d_ren, .d_wen, .d_addr, .d_store, .d_wait
   );

   // taps 16 14 13 11 give a maximal length sequence
   function automatic logic [15:0] lfsr_step(logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic take_bits(inout logic [15:0] state, input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         state = lfsr_step(state);
         v = {v[30:0], state[0]};
      end
   endtask

   // power-up content of memory scrambled over the whole address
   function automatic word_t fill_word(addr_t a);
      return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
   endfunction

   function automatic word_t mem_read(addr_t a);
      if (mem.exists(a))
      begin
         return mem[a];
      end
      return fill_word(a);
   endfunction

   function automatic word_t shadow_read(addr_t a);
      if (shadow.exists(a))
      begin
         return shadow[a];
      end
      return fill_word(a);
   endfunction

   initial
   begin
      CLK = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) CLK = ~CLK;
      end
   end

   // memory side drives a new wait state and read word every falling edge
   initial
   begin
      logic [31:0] r;
      d_wait <= 1'b0;
      d_load <= '0;
      forever
      begin
         @(negedge CLK);
         // stall about one cycle in four
         take_bits(wait_lfsr, 2, r);
         d_wait <= &r[1:0];
         d_load <= mem_read(d_addr);
      end
   end

   // completed write transfers land in memory
   always @(posedge CLK)
   begin
      if (d_wen && !d_wait)
      begin
         mem[d_addr] = d_store;
      end
   end

   // one random read or write held until the cache answers with dhit
   task automatic issue_request();
      logic [31:0] r;
      logic        is_write;
      logic [1:0]  tag_sel;
      set_idx_t    set_sel;
      logic        wsel;
      addr_t       a;
      word_t       data;
      // sometimes leave a gap cycle between requests
      take_bits(stim_lfsr, 2, r);
      if (r[1:0] == 2'b00)
      begin
         dmem_ren <= 1'b0;
         dmem_wen <= 1'b0;
         @(negedge CLK);
      end
      take_bits(stim_lfsr, 1, r);
      is_write = r[0];
      take_bits(stim_lfsr, 4, r);
      tag_sel = 2'(r[3:0] % 4'd3);
      take_bits(stim_lfsr, 3, r);
      set_sel = set_idx_t'(r[2:0]);
      take_bits(stim_lfsr, 1, r);
      wsel = r[0];
      take_bits(stim_lfsr, 32, data);
      a = {tag_t'(TAG_BASE + tag_t'(tag_sel)), set_sel, wsel, 2'b00};
      expected_load <= shadow_read(a);
      dmem_addr     <= a;
      dmem_store    <= data;
      dmem_ren      <= !is_write;
      dmem_wen      <= is_write;
      started       <= 1'b1;
      if (is_write)
      begin
         shadow[a] = data;
      end
      do
      begin
         @(posedge CLK);
      end
      while (!dhit);
      @(negedge CLK);
   endtask

   // after the flush every written word must sit in memory
   task automatic compare_memory();
      foreach (shadow[waddr])
      begin
         assert (mem_read(waddr) == shadow[waddr])
         else
         begin
            mem_errors++;
            $display("[ERROR] %0t: memory at %h holds %h, expected %h",
                     $time, waddr, mem_read(waddr), shadow[waddr]);
         end
      end
   endtask

   // quiet memory bus and flags between reset and the first request
   assert property (@(posedge CLK) disable iff (!nRST)
      !started |-> !d_ren && !d_wen && !dhit && !flushed)
   else
   begin
      check_errors++;
      $display("[ERROR] %0t: bus or status output active before the first request", $time);
   end

   // a read hit returns the last value written there
   assert property (@(posedge CLK) disable iff (!nRST)
      dmem_ren && dhit |-> dmem_load == expected_load)
   else
   begin
      check_errors++;
      $display("[ERROR] %0t: load from %h returned %h, expected %h",
               $time, $sampled(dmem_addr), $sampled(dmem_load), $sampled(expected_load));
   end

   initial
   begin
      int prop_errors;
      nRST       <= 1'b0;
      dmem_ren   <= 1'b0;
      dmem_wen   <= 1'b0;
      dmem_addr  <= '0;
      dmem_store <= '0;
      halt       <= 1'b0;
      repeat (RESET_CYCLES) @(negedge CLK);
      nRST <= 1'b1;
      repeat (2) @(negedge CLK);
      for (int n = 0; n < NUM_REQ; n++)
      begin
         issue_request();
      end
      // stop the processor and walk the flush
      dmem_ren <= 1'b0;
      dmem_wen <= 1'b0;
      halt     <= 1'b1;
      do
      begin
         @(posedge CLK);
      end
      while (!flushed);
      // keep halt up a few more cycles so flushed has to stay high
      repeat (4) @(negedge CLK);
      compare_memory();
      prop_errors = u_dut.u_props.fail_count;
      $display("closing counts: %0d check errors, %0d memory errors, %0d property errors",
               check_errors, mem_errors, prop_errors);
      if (check_errors == 0 && mem_errors == 0 && prop_errors == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the cache stopped answering",
               WATCHDOG_CYCLES);
      $display("Test failed");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_store.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
verification/dcache_props.sv
verification/tb_dcache.sv
